//--- source/jtag_func_decode.sv
`timescale 1ns/10ps

module jtag_func_decode #(
  parameter int N_WR = 3
) (
  input  logic            DRCK,
  input  logic            RST,
  input  logic            sel1,       // Function select instruction
  input  logic            shift,
  input  logic            update,
  input  logic            tdi,
  output logic [N_WR-1:0] fsel,       // One write register, or none
  output logic            dsy_chain,  // All write registers chained
  output logic            rd_sel,     // Status register selected
  output logic            func_tdo    // Function shift stage bit 0
);

  logic [jtag_user_pkg::FUNC_W-1:0] func_sr;  // Shift stage
  jtag_user_pkg::func_word_u        func_q;   // Held function code

  //////////////////////////////
  // Shift and hold
  //////////////////////////////

  always_ff @(posedge DRCK or posedge RST) begin
    if (RST) begin
      func_sr <= jtag_user_pkg::FUNC_RESET;
    end else if (sel1 && shift) begin
      func_sr <= {tdi, func_sr[jtag_user_pkg::FUNC_W-1:1]};  // MSB in, LSB out
    end
  end

  always_ff @(posedge DRCK or posedge RST) begin
    if (RST) begin
      func_q.raw <= jtag_user_pkg::FUNC_RESET;
    end else if (sel1 && update) begin
      func_q.raw <= func_sr;  // Commit on update
    end
  end

  assign func_tdo = func_sr[0];  // Bank gates this with sel1

  //////////////////////////////
  // Decode
  //////////////////////////////

  // Chain beats rd, rd beats index
  assign dsy_chain = func_q.fields.chain;
  assign rd_sel    = func_q.fields.rd & ~func_q.fields.chain;

  genvar i;
  generate
    for (i = 0; i < N_WR; i++) begin : g_fsel
      assign fsel[i] = ~func_q.fields.chain & ~func_q.fields.rd &
                       (int'(func_q.fields.index) == i);  // Out of range index hits nothing
    end
  endgenerate

  // At most one write register addressed
  a_fsel_onehot0 : assert property (@(posedge DRCK) disable iff (RST)
    $onehot0(fsel));

  // Chain mode owns all registers with no single select
  a_fsel_chain : assert property (@(posedge DRCK) disable iff (RST)
    dsy_chain |-> (fsel == '0));

endmodule

//--- source/jtag_tap_if.sv
`timescale 1ns/10ps

// TAP state levels and serial data for the user register bank
interface jtag_tap_if;

  logic sel2;     // Data access instruction active
  logic shift;    // Shift-DR
  logic capture;  // Capture-DR
  logic update;   // Update-DR
  logic tdi;      // Serial data in

  // Register bank side
  modport bank (
    input sel2,
    input shift,
    input capture,
    input update,
    input tdi
  );

  // Driven from the top level pins
  modport src (
    output sel2,
    output shift,
    output capture,
    output update,
    output tdi
  );

endinterface

//--- source/jtag_user_bank.sv
`timescale 1ns/10ps

module jtag_user_bank #(
  parameter int                  N_WR         = 3,
  parameter int                  WR_WIDTH     = 8,
  parameter int                  RD_WIDTH     = 16,
  parameter logic [WR_WIDTH-1:0] WR_DEF_VALUE = '0
) (
  jtag_tap_if.bank                   tap,        // TAP levels and tdi
  input  logic                       DRCK,
  input  logic                       RST,
  input  logic [N_WR-1:0]            fsel,
  input  logic                       dsy_chain,
  input  logic                       rd_sel,
  input  logic                       func_tdo,   // Function register serial out
  input  logic                       sel1,
  input  logic                       load,
  input  logic [N_WR*WR_WIDTH-1:0]   pi,
  input  logic [RD_WIDTH-1:0]        status,
  output logic [N_WR*WR_WIDTH-1:0]   po,
  output logic                       tdo
);

  logic [N_WR:0]   chain;   // chain[i] is dsy_out of register i
  logic [N_WR-1:0] wr_tdo;  // Per register gated serial out
  logic            rd_tdo;
  logic            data_tdo;

  assign chain[N_WR] = tap.tdi;  // Chain enters at the top register

  //////////////////////////////
  // Write registers
  //////////////////////////////

  genvar i;
  generate
    for (i = 0; i < N_WR; i++) begin : g_wr
      user_wr_reg #(
        .WR_WIDTH  (WR_WIDTH),
        .DEF_VALUE (WR_DEF_VALUE)
      ) u_wr (
        .DRCK      (DRCK),
        .RST       (RST),
        .fsel      (fsel[i]),
        .sel       (tap.sel2),
        .tdi       (tap.tdi),
        .dsy_in    (chain[i+1]),                   // From register above
        .shift     (tap.shift),
        .update    (tap.update),
        .dsy_chain (dsy_chain),
        .load      (load),
        .pi        (pi[i*WR_WIDTH +: WR_WIDTH]),
        .po        (po[i*WR_WIDTH +: WR_WIDTH]),
        .tdo       (wr_tdo[i]),
        .dsy_out   (chain[i])
      );
    end
  endgenerate

  //////////////////////////////
  // Status register
  //////////////////////////////

  user_rd_reg #(
    .RD_WIDTH (RD_WIDTH)
  ) u_rd (
    .DRCK    (DRCK),
    .RST     (RST),
    .sel     (tap.sel2),
    .rd_sel  (rd_sel),
    .capture (tap.capture),
    .shift   (tap.shift),
    .tdi     (tap.tdi),
    .status  (status),
    .tdo     (rd_tdo)
  );

  //////////////////////////////
  // TDO select
  //////////////////////////////

  // Outputs are pre-gated, so a plain OR picks the active one
  assign data_tdo = (|wr_tdo) | chain[0] | rd_tdo;

  assign tdo = sel1     ? func_tdo :
               tap.sel2 ? data_tdo :
                          1'b0;           // Idle

  // Only one user instruction at a time
  a_sel_excl : assert property (@(posedge DRCK) disable iff (RST)
    !(sel1 && tap.sel2));

endmodule

//--- source/jtag_user_pkg.sv
package jtag_user_pkg;

  //////////////////////////////
  // Function code layout
  //////////////////////////////

  localparam int FUNC_W = 8;  // Function code width

  // Field view of one function word
  typedef struct packed {
    logic       chain;  // Daisy-chain mode, bit 7
    logic       rd;     // Status register select, bit 6
    logic [1:0] spare;  // Bits 5:4, no meaning yet
    logic [3:0] index;  // Write register number
  } func_fields_t;

  // Same word as shifted bits or as decoded fields
  typedef union packed {
    logic [FUNC_W-1:0] raw;     // Plain code for shifting
    func_fields_t      fields;  // Decode view
  } func_word_u;

  // Index 15 so nothing is selected after reset
  localparam logic [FUNC_W-1:0] FUNC_RESET = 8'h0F;

  //////////////////////////////
  // Default sizes
  //////////////////////////////

  localparam int WR_WIDTH_DEF = 8;   // Bits per write register
  localparam int N_WR_DEF     = 3;   // Write register count
  localparam int RD_WIDTH_DEF = 16;  // Status bits

endpackage

//--- source/jtag_user_top.sv
`timescale 1ns/10ps

module jtag_user_top #(
  parameter int                  WR_WIDTH     = jtag_user_pkg::WR_WIDTH_DEF,
  parameter int                  N_WR         = jtag_user_pkg::N_WR_DEF,
  parameter int                  RD_WIDTH     = jtag_user_pkg::RD_WIDTH_DEF,
  parameter logic [WR_WIDTH-1:0] WR_DEF_VALUE = '0
) (
  input  logic                     DRCK,
  input  logic                     RST,
  input  logic                     sel1,     // Function select instruction
  input  logic                     sel2,     // Data access instruction
  input  logic                     shift,
  input  logic                     capture,
  input  logic                     update,
  input  logic                     tdi,
  input  logic                     load,
  input  logic [N_WR*WR_WIDTH-1:0] pi,
  input  logic [RD_WIDTH-1:0]      status,
  output logic                     tdo,
  output logic [N_WR*WR_WIDTH-1:0] po
);

  logic [N_WR-1:0] fsel;
  logic            dsy_chain;
  logic            rd_sel;
  logic            func_tdo;

  jtag_tap_if tap ();

  // Pins straight onto the bundle
  assign tap.sel2    = sel2;
  assign tap.shift   = shift;
  assign tap.capture = capture;
  assign tap.update  = update;
  assign tap.tdi     = tdi;

  jtag_func_decode #(.N_WR(N_WR)) u_dec (
    .DRCK      (DRCK),
    .RST       (RST),
    .sel1      (sel1),
    .shift     (shift),
    .update    (update),
    .tdi       (tdi),
    .fsel      (fsel),
    .dsy_chain (dsy_chain),
    .rd_sel    (rd_sel),
    .func_tdo  (func_tdo)
  );

  jtag_user_bank #(
    .N_WR         (N_WR),
    .WR_WIDTH     (WR_WIDTH),
    .RD_WIDTH     (RD_WIDTH),
    .WR_DEF_VALUE (WR_DEF_VALUE)
  ) u_bank (
    .tap       (tap),
    .DRCK      (DRCK),
    .RST       (RST),
    .fsel      (fsel),
    .dsy_chain (dsy_chain),
    .rd_sel    (rd_sel),
    .func_tdo  (func_tdo),
    .sel1      (sel1),
    .load      (load),
    .pi        (pi),
    .status    (status),
    .po        (po),
    .tdo       (tdo)
  );

endmodule

//--- source/user_rd_reg.sv
`timescale 1ns/10ps

module user_rd_reg #(
  parameter int RD_WIDTH = 16
) (
  input  logic                DRCK,
  input  logic                RST,
  input  logic                sel,      // Data access active
  input  logic                rd_sel,   // Status register addressed
  input  logic                capture,
  input  logic                shift,
  input  logic                tdi,
  input  logic [RD_WIDTH-1:0] status,   // Parallel status bits
  output logic                tdo
);

  logic [RD_WIDTH-1:0] sr;  // Capture and shift stage
  logic                cap_en;
  logic                shift_en;

  assign cap_en   = sel & rd_sel & capture;
  assign shift_en = sel & rd_sel & shift;

  //////////////////////////////
  // Capture then shift out
  //////////////////////////////

  always_ff @(posedge DRCK or posedge RST) begin
    if (RST) begin
      sr <= '0;
    end else if (cap_en) begin
      sr <= status;                   // Snapshot in one cycle
    end else if (shift_en) begin
      sr <= {tdi, sr[RD_WIDTH-1:1]};  // LSB leaves first
    end
  end

  assign tdo = rd_sel & sr[0];

endmodule

//--- source/user_wr_reg.sv
`timescale 1ns/10ps

module user_wr_reg #(
  parameter int                  WR_WIDTH  = 8,
  parameter logic [WR_WIDTH-1:0] DEF_VALUE = '0
) (
  input  logic                DRCK,
  input  logic                RST,
  input  logic                fsel,       // This register addressed
  input  logic                sel,        // Data access active
  input  logic                tdi,
  input  logic                dsy_in,     // From next register up the chain
  input  logic                shift,
  input  logic                update,
  input  logic                dsy_chain,
  input  logic                load,       // Parallel load strobe
  input  logic [WR_WIDTH-1:0] pi,
  output logic [WR_WIDTH-1:0] po,
  output logic                tdo,
  output logic                dsy_out     // Toward register 0
);

  logic [WR_WIDTH-1:0] sr;  // Shift stage
  logic                din;
  logic                shift_en;
  logic                update_en;

  assign din       = dsy_chain ? dsy_in : tdi;   // Chain input in chain mode
  assign shift_en  = sel & shift & (fsel | dsy_chain);
  assign update_en = sel & update & (fsel | dsy_chain);

  assign tdo     = fsel & sr[0];       // Own serial out
  assign dsy_out = dsy_chain & sr[0];  // Chain serial out

  //////////////////////////////
  // Shift stage
  //////////////////////////////

  always_ff @(posedge DRCK or posedge RST) begin
    if (RST) begin
      sr <= DEF_VALUE;
    end else if (shift_en) begin
      sr <= {din, sr[WR_WIDTH-1:1]};  // Shift right
    end
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  always_ff @(posedge DRCK or posedge RST) begin
    if (RST) begin
      po <= DEF_VALUE;
    end else if (update_en) begin
      po <= sr;  // Update wins over load
    end else if (load) begin
      po <= pi;
    end
  end

  // TAP is never in Shift-DR and Update-DR at once
  a_shift_update : assert property (@(posedge DRCK) disable iff (RST)
    !(shift && update));

endmodule

//--- tests/jtag_user_checker.sv
`timescale 1ns/10ps

module jtag_user_checker #(
  parameter int                  N_WR         = 3,
  parameter int                  WR_WIDTH     = 8,
  parameter int                  RD_WIDTH     = 16,
  parameter logic [WR_WIDTH-1:0] WR_DEF_VALUE = '0
) (
  input logic                     DRCK,
  input logic                     RST,
  input logic                     sel1,
  input logic                     sel2,
  input logic                     shift,
  input logic                     capture,
  input logic                     update,
  input logic                     tdi,
  input logic                     load,
  input logic [N_WR*WR_WIDTH-1:0] pi,
  input logic [RD_WIDTH-1:0]      status,
  input logic                     tdo,
  input logic [N_WR*WR_WIDTH-1:0] po
);

  localparam int TOT = N_WR * WR_WIDTH;

  logic [jtag_user_pkg::FUNC_W-1:0] m_fsr;   // Function shift stage
  jtag_user_pkg::func_word_u        m_func;  // Held function code
  logic [TOT-1:0]                   m_sr;    // All write shift stages, reg 0 at the bottom
  logic [TOT-1:0]                   m_po;
  logic [RD_WIDTH-1:0]              m_rd;    // Status shift stage
  logic                             chain_on;
  logic                             rd_on;
  logic                             idx_ok;
  logic [3:0]                       idx;
  logic                             e_tdo;
  int n_tests = 0;
  int n_errs  = 0;
  int errs_mark = 0;  // Error count when the current test began

  // Chain first, then status, then a valid index
  assign chain_on = m_func.fields.chain;
  assign rd_on    = m_func.fields.rd & ~m_func.fields.chain;
  assign idx      = m_func.fields.index;
  assign idx_ok   = ~m_func.fields.chain & ~m_func.fields.rd & (idx < N_WR);

  //////////////////////////////
  // Reference model
  //////////////////////////////

  always @(posedge DRCK or posedge RST) begin
    if (RST) begin
      m_fsr      <= jtag_user_pkg::FUNC_RESET;
      m_func.raw <= jtag_user_pkg::FUNC_RESET;
      m_sr       <= {N_WR{WR_DEF_VALUE}};
      m_po       <= {N_WR{WR_DEF_VALUE}};
      m_rd       <= '0;
    end else begin
      if (sel1 && shift) m_fsr <= {tdi, m_fsr[jtag_user_pkg::FUNC_W-1:1]};
      if (sel1 && update) m_func.raw <= m_fsr;
      // Whole chain is one long right shift
      if (sel2 && shift && chain_on) m_sr <= {tdi, m_sr[TOT-1:1]};
      else if (sel2 && shift && idx_ok)
        m_sr[idx*WR_WIDTH +: WR_WIDTH] <= {tdi, m_sr[idx*WR_WIDTH+1 +: WR_WIDTH-1]};
      for (int i = 0; i < N_WR; i++) begin
        if (sel2 && update && (chain_on || (idx_ok && idx == i)))
          m_po[i*WR_WIDTH +: WR_WIDTH] <= m_sr[i*WR_WIDTH +: WR_WIDTH];  // Update first
        else if (load)
          m_po[i*WR_WIDTH +: WR_WIDTH] <= pi[i*WR_WIDTH +: WR_WIDTH];
      end
      if (sel2 && rd_on && capture) m_rd <= status;
      else if (sel2 && rd_on && shift) m_rd <= {tdi, m_rd[RD_WIDTH-1:1]};
    end
  end

  // Mid-cycle compare, everything settled
  always @(negedge DRCK) begin
    if (sel1) e_tdo = m_fsr[0];
    else if (sel2 && chain_on) e_tdo = m_sr[0];             // Chain end is reg 0
    else if (sel2 && rd_on) e_tdo = m_rd[0];
    else if (sel2 && idx_ok) e_tdo = m_sr[idx*WR_WIDTH];
    else e_tdo = 1'b0;
    if (po !== m_po) begin
      $display("ERR po got %h exp %h at %0t", po, m_po, $time);
      n_errs++;
    end
    if (tdo !== e_tdo) begin
      $display("ERR tdo got %h exp %h at %0t", tdo, e_tdo, $time);
      n_errs++;
    end
  end

  // Read result against table, one line per test
  task automatic finish_test(input string name, input string sig,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s (%s) got %h exp %h", sig, name, got, exp);
      n_errs++;
    end
    n_tests++;
    $display("%s %0d %s", (n_errs == errs_mark) ? "PASS" : "FAIL", n_tests, name);
    errs_mark = n_errs;
  endtask

endmodule

//--- tests/jtag_user_tb.sv
`timescale 1ns/10ps

module jtag_user_tb;

  localparam int WR_W    = jtag_user_pkg::WR_WIDTH_DEF;
  localparam int N_WR    = jtag_user_pkg::N_WR_DEF;
  localparam int RD_W    = jtag_user_pkg::RD_WIDTH_DEF;
  localparam int TOT     = N_WR * WR_W;
  localparam int EDGE_TO = 50;  // Edge timeout in ns, well beyond a half period

  localparam int OP_PEEK   = 0;  // Just read po
  localparam int OP_WRITE  = 1;  // Code, then one data access
  localparam int OP_STATUS = 2;  // Code, capture, shift out
  localparam int OP_LOAD   = 3;  // Load strobe alone
  localparam int OP_LDUPD  = 4;  // Write with load high on the update edge

  logic            DRCK;
  logic            RST;
  logic            sel1;
  logic            sel2;
  logic            shift;
  logic            capture;
  logic            update;
  logic            tdi;
  logic            load;
  logic [TOT-1:0]  pi;
  logic [RD_W-1:0] status;
  logic            tdo;
  logic [TOT-1:0]  po;

  // Stimulus table with one column per queue
  int          op_q[$];
  logic [7:0]  code_q[$];
  logic [31:0] data_q[$];
  logic [31:0] pi_q[$];
  logic [31:0] exp_q[$];
  string       name_q[$];

  bit              timed_out;
  int              rnd;
  logic [31:0]     got;
  logic [WR_W-1:0] d1, d2, d3, d4, d5;
  logic [TOT-1:0]  c, p1, p2;
  logic [RD_W-1:0] s;

  jtag_user_top dut (.*);

  jtag_user_checker #(
    .N_WR (N_WR), .WR_WIDTH (WR_W), .RD_WIDTH (RD_W), .WR_DEF_VALUE ('0)
  ) u_chk (.*);

  initial begin
    DRCK = 1'b0;
    forever #5 DRCK = ~DRCK;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic wait_edge(input bit rising, input string what);
    timed_out = 1'b0;
    fork
      begin
        if (rising) @(posedge DRCK);
        else @(negedge DRCK);
      end
      begin
        #(EDGE_TO);
        timed_out = 1'b1;
      end
    join_any
    disable fork;
    if (timed_out) begin
      $display("Timeout: no clock edge within %0d ns while waiting for %s", EDGE_TO, what);
      $display("Test FAILED");
      $finish;
    end
  endtask

  task automatic add_test(input int op, input logic [7:0] code, input logic [31:0] data,
                          input logic [31:0] pv, input logic [31:0] ex, input string name);
    op_q.push_back(op);
    code_q.push_back(code);
    data_q.push_back(data);
    pi_q.push_back(pv);
    exp_q.push_back(ex);
    name_q.push_back(name);
  endtask

  // One DR access under sel1 (fn) or sel2 with bits out collected LSB first
  task automatic shift_access(input bit fn, input int n, input logic [31:0] data,
                              input bit cap, input bit ld, output logic [31:0] bits_out);
    bits_out = '0;
    wait_edge(1'b1, "access start");
    if (fn) sel1 <= 1'b1;
    else sel2 <= 1'b1;
    if (cap) begin
      capture <= 1'b1;
      wait_edge(1'b1, "capture");
      capture <= 1'b0;
    end
    shift <= 1'b1;
    tdi   <= data[0];
    for (int k = 0; k < n; k++) begin
      wait_edge(1'b0, "shift sample");
      bits_out[k] = tdo;          // Bit 0 before it leaves
      wait_edge(1'b1, "shift");
      if (k < n - 1) tdi <= data[k+1];
      else begin
        shift  <= 1'b0;
        update <= !cap;           // Status read needs no update
        load   <= ld;
      end
    end
    wait_edge(1'b1, "update");
    update <= 1'b0;
    load   <= 1'b0;
    sel1   <= 1'b0;
    sel2   <= 1'b0;
    tdi    <= 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST = 1'b1;
    sel1 = 1'b0;
    sel2 = 1'b0;
    shift = 1'b0;
    capture = 1'b0;
    update = 1'b0;
    tdi = 1'b0;
    load = 1'b0;
    pi = '0;
    status = '0;
    rnd = $urandom(38);
    d1 = $urandom;
    d2 = $urandom;
    d3 = $urandom;
    d4 = $urandom;
    d5 = $urandom;
    c  = $urandom;
    p1 = $urandom;
    p2 = $urandom;
    s  = $urandom;
    status = s;  // Held for the whole run

    // Expected values follow shift history from all-zero reset stages
    add_test(OP_PEEK,   8'h00, 0,  0,  0,                       "reset po");
    add_test(OP_WRITE,  8'h01, d1, 0,  0,                       "write reg1 first");
    add_test(OP_WRITE,  8'h01, d2, 0,  d1,                      "write reg1 again");
    add_test(OP_WRITE,  8'h02, d3, 0,  0,                       "write reg2");
    add_test(OP_WRITE,  8'h80, c,  0,  {d3, d2, {WR_W{1'b0}}},  "chain write");
    add_test(OP_STATUS, 8'h40, 0,  0,  s,                       "status read");
    add_test(OP_LOAD,   8'h00, 0,  p1, p1,                      "load all");
    add_test(OP_LDUPD,  8'h00, d4, p2, {p2[TOT-1:WR_W], d4},    "update beats load");
    add_test(OP_WRITE,  8'h03, d5, 0,  0,                       "index N_WR");
    add_test(OP_WRITE,  8'h35, d5, 0,  0,                       "index 5");
    add_test(OP_PEEK,   8'h00, 0,  0,  {p2[TOT-1:WR_W], d4},    "po after bad index");

    for (int i = 0; i < 2; i++) wait_edge(1'b1, "reset");
    RST <= 1'b0;

    for (int t = 0; t < op_q.size(); t++) begin
      got = '0;
      case (op_q[t])
        OP_WRITE: begin
          shift_access(1'b1, jtag_user_pkg::FUNC_W, code_q[t], 1'b0, 1'b0, got);
          shift_access(1'b0, code_q[t][7] ? TOT : WR_W, data_q[t], 1'b0, 1'b0, got);
        end
        OP_STATUS: begin
          shift_access(1'b1, jtag_user_pkg::FUNC_W, code_q[t], 1'b0, 1'b0, got);
          shift_access(1'b0, RD_W, '0, 1'b1, 1'b0, got);
        end
        OP_LOAD: begin
          wait_edge(1'b1, "load");
          pi   <= pi_q[t];
          load <= 1'b1;
          wait_edge(1'b1, "load end");
          load <= 1'b0;
        end
        OP_LDUPD: begin
          wait_edge(1'b1, "pi setup");
          pi <= pi_q[t];
          shift_access(1'b1, jtag_user_pkg::FUNC_W, code_q[t], 1'b0, 1'b0, got);
          shift_access(1'b0, WR_W, data_q[t], 1'b0, 1'b1, got);
        end
        default: ;
      endcase
      wait_edge(1'b0, "result sample");  // Last update or load now on po
      if (op_q[t] == OP_PEEK || op_q[t] == OP_LOAD || op_q[t] == OP_LDUPD) begin
        got = po;
      end
      wait_edge(1'b1, "result");
      if (op_q[t] == OP_PEEK || op_q[t] == OP_LOAD || op_q[t] == OP_LDUPD) begin
        u_chk.finish_test(name_q[t], "po", got, exp_q[t]);
      end else begin
        u_chk.finish_test(name_q[t], "tdo", got, exp_q[t]);
      end
    end

    wait_edge(1'b1, "drain");
    $display("Tests run %0d, errors %0d", u_chk.n_tests, u_chk.n_errs);
    if (u_chk.n_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
source/jtag_user_pkg.sv
source/jtag_tap_if.sv
source/jtag_func_decode.sv
source/user_wr_reg.sv
source/user_rd_reg.sv
source/jtag_user_bank.sv
source/jtag_user_top.sv
tests/jtag_user_checker.sv
tests/jtag_user_tb.sv
